// ==== Bender.yml ====
package:
  name: dbg_access

sources:
  - include_dirs:
      - .
    files:
      - soc_dbg_pkg.sv
      - dbg_decode.sv
      - dbg_execute.sv
      - dbg_result.sv
      - dbg_access_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - dbg_access_assert.sv
      - tb_dbg_access.sv

// ==== dbg_access_assert.sv ====
// Four-phase handshake assertions for the debug access top, attached by bind
`default_nettype none
`timescale 1ns/10ps

module dbg_access_assert (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_i,
  input logic                   ack_i,
  input soc_dbg_pkg::dmi_resp_t resp_i
);

  // Capture edge, execute edge, result edge
  ack_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(req_i) |-> !ack_i [*3] ##1 ack_i)
    else $error("ack_o did not rise three cycles after the request");

  ack_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_i && req_i) |=> ack_i)
    else $error("ack_o dropped while req_i was still high");

  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> (!ack_i || $stable(resp_i)))
    else $error("resp_o changed while ack_o was high");

  // From reset on, ack_o stays low until a request arrives
  ack_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!req_i && !ack_i) |=> !ack_i)
    else $error("ack_o rose without a request");

endmodule

bind dbg_access_top dbg_access_assert i_dbg_access_assert (
  .clk_i  ( clk_i  ),
  .rst_ni ( rst_ni ),
  .req_i  ( req_i  ),
  .ack_i  ( ack_o  ),
  .resp_i ( resp_o )
);

`default_nettype wire

// ==== dbg_access_top.sv ====
// Debug access path top with decode, execute and result stages
`default_nettype none
`timescale 1ns/10ps

module dbg_access_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  soc_dbg_pkg::dmi_req_t  req_data_i,
  output logic                   ack_o,
  output soc_dbg_pkg::dmi_resp_t resp_o
);

  logic                   dec_valid;
  soc_dbg_pkg::dec_req_t  dec_req;
  logic                   exe_valid;
  soc_dbg_pkg::dmi_resp_t exe_resp;

  // --------------------------------------------------
  // Stages
  // --------------------------------------------------
  // ack_o feeds back so decode re-arms after the handshake closes
  dbg_decode i_dbg_decode (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .req_i       ( req_i      ),
    .req_data_i  ( req_data_i ),
    .ack_i       ( ack_o      ),
    .dec_valid_o ( dec_valid  ),
    .dec_req_o   ( dec_req    )
  );

  dbg_execute i_dbg_execute (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .dec_valid_i ( dec_valid ),
    .dec_req_i   ( dec_req   ),
    .exe_valid_o ( exe_valid ),
    .exe_resp_o  ( exe_resp  )
  );

  dbg_result i_dbg_result (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .exe_valid_i ( exe_valid ),
    .exe_resp_i  ( exe_resp  ),
    .req_i       ( req_i     ),
    .ack_o       ( ack_o     ),
    .resp_o      ( resp_o    )
  );

endmodule

`default_nettype wire

// ==== dbg_decode.sv ====
// Debug access decode stage that captures requests and maps addresses to regions
`default_nettype none
`timescale 1ns/10ps

`include "soc_dbg_macros.svh"

module dbg_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  soc_dbg_pkg::dmi_req_t req_data_i,
  input  logic                  ack_i,
  output logic                  dec_valid_o,
  output soc_dbg_pkg::dec_req_t dec_req_o
);

  localparam logic [`DMI_ADDR_W-1:0] RomWords = `ROM_WORDS;
  localparam logic [`DMI_ADDR_W-1:0] SpmWords = `SPM_WORDS;

  logic                   armed_q;
  logic                   drop_q;
  logic                   armed;
  logic                   capture;
  logic                   dec_valid_q;
  logic [`DMI_ADDR_W-1:0] rom_off;
  logic [`DMI_ADDR_W-1:0] spm_off;
  soc_dbg_pkg::dec_req_t  dec_d;
  soc_dbg_pkg::dec_req_t  dec_q;

  // --------------------------------------------------
  // Capture control
  // --------------------------------------------------
  // After a capture, wait for req_i to drop and then for ack_i to drop
  assign armed   = armed_q | (drop_q & ~ack_i);
  assign capture = armed & req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q     <= 1'b1;
      drop_q      <= 1'b0;
      dec_valid_q <= 1'b0;
    end else begin
      armed_q     <= armed & ~capture;
      drop_q      <= ~armed & (drop_q | ~req_i);
      dec_valid_q <= capture;
    end
  end

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  // Addresses below a base wrap to large offsets and miss the region
  assign rom_off = req_data_i.addr - `ROM_BASE;
  assign spm_off = req_data_i.addr - `SPM_BASE;

  always_comb begin
    dec_d.op   = req_data_i.op;
    dec_d.data = req_data_i.data;
    if (rom_off < RomWords) begin
      dec_d.region = soc_dbg_pkg::REGION_ROM;
      dec_d.offset = rom_off[3:0];
    end else if (spm_off < SpmWords) begin
      dec_d.region = soc_dbg_pkg::REGION_SPM;
      dec_d.offset = spm_off[3:0];
    end else begin
      dec_d.region = soc_dbg_pkg::REGION_NONE;
      dec_d.offset = '0;
    end
  end

  // Decoded request payload
  always_ff @(posedge clk_i) begin
    if (capture) begin
      dec_q <= dec_d;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_req_o   = dec_q;

endmodule

`default_nettype wire

// ==== dbg_execute.sv ====
// Debug access execute stage with boot ROM lookup, scratchpad and response generation
`default_nettype none
`timescale 1ns/10ps

`include "soc_dbg_macros.svh"

module dbg_execute (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   dec_valid_i,
  input  soc_dbg_pkg::dec_req_t  dec_req_i,
  output logic                   exe_valid_o,
  output soc_dbg_pkg::dmi_resp_t exe_resp_o
);

  logic [`DMI_DATA_W-1:0] spm_q [`SPM_WORDS];
  logic [`DMI_DATA_W-1:0] rom_word;
  logic                   spm_we;
  logic                   exe_valid_q;
  soc_dbg_pkg::dmi_resp_t resp_d;
  soc_dbg_pkg::dmi_resp_t resp_q;

  // --------------------------------------------------
  // Targets
  // --------------------------------------------------
  // Boot ROM word is the tag followed by the word offset
  assign rom_word = {`ROM_TAG, 16'(dec_req_i.offset)};

  assign spm_we = dec_valid_i &&
                  (dec_req_i.region == soc_dbg_pkg::REGION_SPM) &&
                  (dec_req_i.op == soc_dbg_pkg::OP_WRITE);

  // Scratchpad clears on reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `SPM_WORDS; i++) begin
        spm_q[i] <= '0;
      end
    end else if (spm_we) begin
      spm_q[dec_req_i.offset] <= dec_req_i.data;
    end
  end

  // --------------------------------------------------
  // Response rules
  // --------------------------------------------------
  always_comb begin
    resp_d.resp = soc_dbg_pkg::RESP_OK;
    resp_d.data = '0;
    case (dec_req_i.op)
      soc_dbg_pkg::OP_READ: begin
        case (dec_req_i.region)
          soc_dbg_pkg::REGION_ROM: resp_d.data = rom_word;
          soc_dbg_pkg::REGION_SPM: resp_d.data = spm_q[dec_req_i.offset];
          default:                 resp_d.resp = soc_dbg_pkg::RESP_DECERR;
        endcase
      end
      soc_dbg_pkg::OP_WRITE: begin
        case (dec_req_i.region)
          // ROM ignores the write
          soc_dbg_pkg::REGION_ROM: resp_d.resp = soc_dbg_pkg::RESP_SLVERR;
          soc_dbg_pkg::REGION_SPM: resp_d.resp = soc_dbg_pkg::RESP_OK;
          default:                 resp_d.resp = soc_dbg_pkg::RESP_DECERR;
        endcase
      end
      // NOP and unused encodings
      default: begin
        resp_d.resp = soc_dbg_pkg::RESP_OK;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exe_valid_q <= 1'b0;
    end else begin
      exe_valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      resp_q <= resp_d;
    end
  end

  assign exe_valid_o = exe_valid_q;
  assign exe_resp_o  = resp_q;

endmodule

`default_nettype wire

// ==== dbg_patterns.txt ====
# op addr data exp_resp exp_data (hex), hold (decimal extra cycles with req high)
# op: 0 nop, 1 read, 2 write; resp: 0 ok, 2 slverr, 3 decerr
1 20 00000000 0 00000000 0
1 25 00000000 0 00000000 0
1 2f 00000000 0 00000000 0
1 00 00000000 0 b0070000 0
1 05 00000000 0 b0070005 0
1 0f 00000000 0 b007000f 0
2 21 deadbeef 0 00000000 0
2 2a 12345678 0 00000000 0
1 21 00000000 0 deadbeef 0
1 2a 00000000 0 12345678 0
1 22 00000000 0 00000000 0
1 2f 00000000 0 00000000 0
2 03 ffffffff 2 00000000 0
1 03 00000000 0 b0070003 0
1 10 00000000 3 00000000 0
2 40 a5a5a5a5 3 00000000 0
1 7f 00000000 3 00000000 0
1 30 00000000 3 00000000 0
0 20 11111111 0 00000000 0
0 7f 22222222 0 00000000 0
2 2c cafef00d 0 00000000 5
1 2c 00000000 0 cafef00d 4
1 21 00000000 0 deadbeef 0
1 2b 00000000 0 00000000 0

// ==== dbg_result.sv ====
// Debug access result stage that holds the response and drives the four-phase ack
`default_nettype none
`timescale 1ns/10ps

module dbg_result (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   exe_valid_i,
  input  soc_dbg_pkg::dmi_resp_t exe_resp_i,
  input  logic                   req_i,
  output logic                   ack_o,
  output soc_dbg_pkg::dmi_resp_t resp_o
);

  soc_dbg_pkg::res_state_e state_d;
  soc_dbg_pkg::res_state_e state_q;
  soc_dbg_pkg::dmi_resp_t  resp_q;
  logic                    latch;

  // --------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------
  assign latch = (state_q == soc_dbg_pkg::RES_IDLE) && exe_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_dbg_pkg::RES_IDLE: begin
        if (exe_valid_i) begin
          state_d = soc_dbg_pkg::RES_ACK;
        end
      end
      // Hold ack for as long as the master keeps req_i high
      soc_dbg_pkg::RES_ACK: begin
        if (!req_i) begin
          state_d = soc_dbg_pkg::RES_WAIT_DROP;
        end
      end
      soc_dbg_pkg::RES_WAIT_DROP: begin
        state_d = soc_dbg_pkg::RES_IDLE;
      end
      default: begin
        state_d = soc_dbg_pkg::RES_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= soc_dbg_pkg::RES_IDLE;
      resp_q  <= '0;
    end else begin
      state_q <= state_d;
      if (latch) begin
        resp_q <= exe_resp_i;
      end
    end
  end

  // Ack is a decoded register bit
  assign ack_o  = (state_q == soc_dbg_pkg::RES_ACK);
  assign resp_o = resp_q;

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
soc_dbg_pkg.sv
dbg_decode.sv
dbg_execute.sv
dbg_result.sv
dbg_access_top.sv
tb_clk_gen.sv
dbg_access_assert.sv
tb_dbg_access.sv

// ==== soc_dbg_macros.svh ====
// Debug access path bus widths and address map constants

`ifndef SOC_DBG_MACROS_SVH
`define SOC_DBG_MACROS_SVH

// --------------------------------------------------
// Debug module interface widths
// --------------------------------------------------
`define DMI_ADDR_W 7
`define DMI_DATA_W 32

// --------------------------------------------------
// Address map
// --------------------------------------------------

// Boot ROM region
`define ROM_BASE  7'h00
`define ROM_WORDS 16

// Scratchpad region standing in for the L2 memory
`define SPM_BASE  7'h20
`define SPM_WORDS 16

// Upper half of every boot ROM word
`define ROM_TAG 16'hB007

`endif

// ==== soc_dbg_pkg.sv ====
// Shared types for the debug access path: operations, responses, regions and states
`default_nettype none

`include "soc_dbg_macros.svh"

package soc_dbg_pkg;

  // --------------------------------------------------
  // Debug module interface encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } dmi_op_e;

  // Same codes as the AXI error responses
  typedef enum logic [1:0] {
    RESP_OK     = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } dmi_resp_e;

  // Decoded target of an access
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_SPM,
    REGION_NONE
  } region_e;

  // Result stage handshake FSM
  typedef enum logic [1:0] {
    RES_IDLE,
    RES_ACK,
    RES_WAIT_DROP
  } res_state_e;

  // --------------------------------------------------
  // Bundles between the stages
  // --------------------------------------------------
  typedef struct packed {
    dmi_op_e                op;
    logic [`DMI_ADDR_W-1:0] addr;
    logic [`DMI_DATA_W-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    dmi_resp_e              resp;
    logic [`DMI_DATA_W-1:0] data;
  } dmi_resp_t;

  // Offset covers 16 words in either region
  typedef struct packed {
    region_e                region;
    dmi_op_e                op;
    logic [3:0]             offset;
    logic [`DMI_DATA_W-1:0] data;
  } dec_req_t;

endpackage

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock and reset generator for the debug access path
`default_nettype none
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int ClkPeriodNs = 100;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset held over the first two rising edges, released on a falling edge
  initial begin
    rst_no = 1'b0;
    #(2 * ClkPeriodNs);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_dbg_access.sv ====
// Testbench for the debug access path driven from a pattern file
`default_nettype none
`timescale 1ns/10ps

module tb_dbg_access;

  localparam int ClkPeriodNs = 100;
  localparam int CyclesPerPattern = 20;

  // One access from the pattern file
  typedef struct packed {
    logic [1:0]  op;
    logic [6:0]  addr;
    logic [31:0] data;
    logic [1:0]  resp;
    logic [31:0] rdata;
    logic [7:0]  hold;
  } pattern_t;

  logic                   clk;
  logic                   rst_n;
  logic                   req;
  soc_dbg_pkg::dmi_req_t  req_data;
  logic                   ack;
  soc_dbg_pkg::dmi_resp_t resp;

  pattern_t patterns[$];
  logic     load_done;

  tb_clk_gen i_tb_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  dbg_access_top dut (
    .clk_i      ( clk      ),
    .rst_ni     ( rst_n    ),
    .req_i      ( req      ),
    .req_data_i ( req_data ),
    .ack_o      ( ack      ),
    .resp_o     ( resp     )
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic read_patterns();
    int          fd;
    int          n;
    int          line_no;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_resp;
    logic [31:0] f_rdata;
    int          f_hold;
    pattern_t    p;
    line_no = 0;
    fd = $fopen("dbg_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file dbg_patterns.txt");
      $display("Finished with errors");
      $fatal(1);
    end
    while ($fgets(line, fd)) begin
      line_no++;
      // Comments and blank lines
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %d", f_op, f_addr, f_data, f_resp, f_rdata, f_hold);
      if (n != 6) begin
        $display("Pattern file line %0d does not hold six fields", line_no);
        $display("Finished with errors");
        $fatal(1);
      end
      p.op    = f_op[1:0];
      p.addr  = f_addr[6:0];
      p.data  = f_data;
      p.resp  = f_resp[1:0];
      p.rdata = f_rdata;
      p.hold  = f_hold[7:0];
      patterns.push_back(p);
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // One four-phase access
  // --------------------------------------------------
  task automatic run_access(input pattern_t p);
    logic [31:0] held_data;
    @(negedge clk);
    req_data.op   = soc_dbg_pkg::dmi_op_e'(p.op);
    req_data.addr = p.addr;
    req_data.data = p.data;
    req           = 1'b1;
    do @(negedge clk); while (ack !== 1'b1);
    check_value("resp_o.resp", 32'(resp.resp), 32'(p.resp));
    check_value("resp_o.data", resp.data, p.rdata);
    held_data = resp.data;
    // Master stalls with req_i still high and other data on the bus,
    // so a second capture would leave a different word behind
    req_data.data = ~p.data;
    repeat (p.hold) begin
      @(negedge clk);
      check_value("ack_o", 32'(ack), 32'd1);
      check_value("resp_o.data", resp.data, held_data);
    end
    req = 1'b0;
    do @(negedge clk); while (ack !== 1'b0);
  endtask

  initial begin
    req       = 1'b0;
    req_data  = '0;
    load_done = 1'b0;
    read_patterns();
    load_done = 1'b1;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_value("ack_o", 32'(ack), 32'd0);
    foreach (patterns[i]) begin
      run_access(patterns[i]);
    end
    $display("Finished with no errors");
    $finish;
  end

  // Watchdog scaled to the number of accesses
  initial begin
    wait (load_done === 1'b1);
    #(patterns.size() * CyclesPerPattern * ClkPeriodNs);
    $display("Timeout: the accesses did not complete in time");
    $display("Finished with errors");
    $fatal(1);
  end

endmodule

`default_nettype wire
